// ==== Makefile ====
.PHONY: run clean

obj_dir/Vcpu_tb: compile.f $(wildcard hw/*.sv hw/*.svh testbench/*.sv)
	verilator --binary --timing --assert --top-module cpu_tb -f compile.f

run: obj_dir/Vcpu_tb
	./obj_dir/Vcpu_tb 2>&1 | tee sim.log
	@if grep -q '>>> FAIL' sim.log; then echo "simulation failed"; exit 1; fi
	@grep -q '>>> PASS' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== compile.f ====
+incdir+hw
hw/cpu_pkg.sv
hw/fetch_unit.sv
hw/cpu_controller.sv
hw/execute_unit.sv
hw/memory_writeback.sv
hw/cpu_top.sv
testbench/cpu_assertions.sv
testbench/cpu_tb.sv

// ==== hw/cpu_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_controller (
	input logic clock,
	input logic reset,
	input logic run,
	input cpu_pkg::inst_t instruction,
	output logic pc_enable,
	output logic fetch_enable,
	output logic execute_enable,
	output logic memory_enable,
	output logic writeback_enable,
	output cpu_pkg::control_t control
);
	import cpu_pkg::*;

	cpu_state_t state;
	cpu_state_t next_state;
	opcode_t opcode;

	assign opcode = instruction[`OPCODE_FIELD];

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			state <= state_pc;
		end else begin
			state <= next_state;
		end
	end

	// idle in state_pc until run
	always_comb begin
		case (state)
			state_pc: next_state = run ? state_fetch : state_pc;
			state_fetch: next_state = state_execute;
			state_execute: next_state = state_memory;
			state_memory: next_state = state_writeback;
			default: next_state = state_pc;
		endcase
	end

	assign pc_enable = (state == state_pc) && run;
	assign fetch_enable = (state == state_fetch);
	assign execute_enable = (state == state_execute);
	assign memory_enable = (state == state_memory);
	assign writeback_enable = (state == state_writeback);

	always_comb begin
		control.imm_sel = imm_none;
		control.alu_src = alu_reg;
		control.wb_sel = wb_alu;
		control.dm_read = 1'b0;
		control.dm_write = 1'b0;
		control.reg_write = 1'b0;
		control.alu_op = `ADD;
		case (opcode)
			`TY_BASE: begin
				case (instruction[`SUBOP_FIELD])
					`ADD, `SUB, `AND, `OR, `XOR, `SRLI, `SLLI, `ROTRI: begin
						control.reg_write = 1'b1;
						control.alu_op = instruction[`SUBOP_FIELD];
					end
					default: begin
						control.reg_write = 1'b0;
					end
				endcase
			end
			`ADDI: begin
				control.imm_sel = imm_15;
				control.alu_src = alu_sext_add;
				control.reg_write = 1'b1;
			end
			`ORI, `XORI: begin
				control.imm_sel = imm_15;
				control.alu_src = alu_zext_logic;
				control.reg_write = 1'b1;
				control.alu_op = (opcode == `ORI) ? `OR : `XOR;
			end
			`MOVI: begin
				control.alu_src = alu_move_imm;
				control.wb_sel = wb_imm;
				control.reg_write = 1'b1;
			end
			`LWI, `SWI: begin
				control.imm_sel = imm_15_x4;
				control.alu_src = alu_sext_add;
				control.wb_sel = wb_mem;
				control.dm_read = (opcode == `LWI);
				control.dm_write = (opcode == `SWI);
				control.reg_write = (opcode == `LWI);
			end
			`TY_LS: begin
				control.imm_sel = imm_index;
				control.alu_src = alu_sext_add;
				control.wb_sel = wb_mem;
				case (instruction[`SUBOP_LS_FIELD])
					`LW: begin
						control.dm_read = 1'b1;
						control.reg_write = 1'b1;
					end
					`SW: begin
						control.dm_write = 1'b1;
					end
					default: begin
						control.dm_read = 1'b0;
					end
				endcase
			end
			default: begin
				control.reg_write = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== hw/cpu_defs.svh ====
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// major opcodes in bits 30 to 25
`define TY_BASE 6'b100000
`define ADDI 6'b101000
`define ORI 6'b101100
`define XORI 6'b101011
`define MOVI 6'b100010
`define LWI 6'b000100
`define SWI 6'b010100
`define TY_LS 6'b011100

// base sub-opcodes in bits 4 to 0
`define ADD 5'b00000
`define SUB 5'b00001
`define AND 5'b00010
`define XOR 5'b00011
`define OR 5'b00100
`define SLLI 5'b01000
`define SRLI 5'b01001
`define ROTRI 5'b01011

// load/store sub-opcodes in bits 7 to 0
`define LW 8'b00000010
`define SW 8'b00001010

// instruction fields
`define OPCODE_FIELD 30:25
`define SUBOP_FIELD 4:0
`define SUBOP_LS_FIELD 7:0
`define RT_FIELD 24:20
`define RA_FIELD 19:15
`define RB_FIELD 14:10
`define SHAMT_FIELD 14:10
`define SV_FIELD 9:8
`define IMM15_FIELD 14:0
`define IMM15_SIGN 14
`define IMM20_FIELD 19:0
`define IMM20_SIGN 19

// memory depths and the word index within a byte address
`define IMEM_DEPTH 64
`define DMEM_DEPTH 64
`define WORD_INDEX_FIELD 7:2

`endif

// ==== hw/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] inst_t;
	typedef logic [4:0] reg_idx_t;
	typedef logic [31:0] pc_t;
	typedef logic [5:0] opcode_t;
	typedef logic [5:0] imem_addr_t;

	typedef enum logic [2:0] {
		state_pc,
		state_fetch,
		state_execute,
		state_memory,
		state_writeback
	} cpu_state_t;

	typedef enum logic [1:0] {
		imm_none,
		imm_15,
		imm_15_x4,
		imm_index
	} imm_sel_t;

	typedef enum logic [1:0] {
		alu_reg,
		alu_sext_add,
		alu_zext_logic,
		alu_move_imm
	} alu_src_t;

	typedef enum logic [1:0] {
		wb_alu,
		wb_imm,
		wb_mem
	} wb_sel_t;

	typedef struct packed {
		imm_sel_t imm_sel;
		alu_src_t alu_src;
		wb_sel_t wb_sel;
		logic dm_read;
		logic dm_write;
		logic reg_write;
		logic [4:0] alu_op;
	} control_t;

	typedef struct packed {
		logic valid;
		reg_idx_t rt;
		word_t value;
	} retire_t;

	typedef struct packed {
		logic valid;
		word_t address;
		word_t data;
	} store_t;

endpackage

`default_nettype wire

// ==== hw/cpu_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_top (
	input logic clock,
	input logic reset,
	input logic run,
	input logic load_enable,
	input cpu_pkg::imem_addr_t load_address,
	input cpu_pkg::inst_t load_instruction,
	output cpu_pkg::retire_t retire,
	output cpu_pkg::store_t store
);
	import cpu_pkg::*;

	inst_t instruction;
	control_t control;
	logic pc_enable;
	logic fetch_enable;
	logic execute_enable;
	logic memory_enable;
	logic writeback_enable;
	word_t alu_result;
	word_t store_data;
	word_t writeback_value;

	fetch_unit fetch_unit_inst (
		.clock(clock),
		.reset(reset),
		.pc_enable(pc_enable),
		.fetch_enable(fetch_enable),
		.load_enable(load_enable),
		.load_address(load_address),
		.load_instruction(load_instruction),
		.instruction(instruction)
	);

	cpu_controller cpu_controller_inst (
		.clock(clock),
		.reset(reset),
		.run(run),
		.instruction(instruction),
		.pc_enable(pc_enable),
		.fetch_enable(fetch_enable),
		.execute_enable(execute_enable),
		.memory_enable(memory_enable),
		.writeback_enable(writeback_enable),
		.control(control)
	);

	execute_unit execute_unit_inst (
		.clock(clock),
		.reset(reset),
		.execute_enable(execute_enable),
		.writeback_enable(writeback_enable),
		.instruction(instruction),
		.control(control),
		.writeback_value(writeback_value),
		.alu_result(alu_result),
		.store_data(store_data),
		.retire(retire)
	);

	memory_writeback memory_writeback_inst (
		.clock(clock),
		.reset(reset),
		.memory_enable(memory_enable),
		.control(control),
		.alu_result(alu_result),
		.store_data(store_data),
		.writeback_value(writeback_value),
		.store(store)
	);

endmodule

`default_nettype wire

// ==== hw/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module execute_unit (
	input logic clock,
	input logic reset,
	input logic execute_enable,
	input logic writeback_enable,
	input cpu_pkg::inst_t instruction,
	input cpu_pkg::control_t control,
	input cpu_pkg::word_t writeback_value,
	output cpu_pkg::word_t alu_result,
	output cpu_pkg::word_t store_data,
	output cpu_pkg::retire_t retire
);
	import cpu_pkg::*;

	word_t regs [0:31];
	reg_idx_t rt;
	reg_idx_t ra;
	reg_idx_t rb;
	logic [4:0] shamt;
	word_t operand_a;
	word_t operand_b;
	word_t immediate;
	word_t alu_value;
	logic [63:0] rotate_wide;

	assign rt = instruction[`RT_FIELD];
	assign ra = instruction[`RA_FIELD];
	assign rb = instruction[`RB_FIELD];
	assign shamt = instruction[`SHAMT_FIELD];

	// ori/xori take the zero-extended form
	always_comb begin
		case (control.imm_sel)
			imm_15: begin
				if (control.alu_src == alu_zext_logic) begin
					immediate = {17'd0, instruction[`IMM15_FIELD]};
				end else begin
					immediate = {{17{instruction[`IMM15_SIGN]}}, instruction[`IMM15_FIELD]};
				end
			end
			imm_15_x4: immediate = {{15{instruction[`IMM15_SIGN]}}, instruction[`IMM15_FIELD], 2'b00};
			imm_index: immediate = regs[rb] << instruction[`SV_FIELD];
			default: immediate = '0;
		endcase
	end

	assign operand_a = regs[ra];
	assign operand_b = (control.imm_sel == imm_none) ? regs[rb] : immediate;
	assign rotate_wide = {operand_a, operand_a} >> shamt;

	always_comb begin
		case (control.alu_op)
			`ADD: alu_value = operand_a + operand_b;
			`SUB: alu_value = operand_a - operand_b;
			`AND: alu_value = operand_a & operand_b;
			`OR: alu_value = operand_a | operand_b;
			`XOR: alu_value = operand_a ^ operand_b;
			`SRLI: alu_value = operand_a >> shamt;
			`SLLI: alu_value = operand_a << shamt;
			`ROTRI: alu_value = rotate_wide[31:0];
			default: alu_value = operand_a + operand_b;
		endcase
		if (control.alu_src == alu_move_imm) begin
			alu_value = {{12{instruction[`IMM20_SIGN]}}, instruction[`IMM20_FIELD]};
		end
	end

	// result doubles as load/store address
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			alu_result <= '0;
			store_data <= '0;
		end else if (execute_enable) begin
			alu_result <= alu_value;
			store_data <= regs[rt];
		end
	end

	// r0 is an ordinary register here
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			for (int i = 0; i < 32; i++) begin
				regs[i] <= '0;
			end
		end else if (writeback_enable && control.reg_write) begin
			regs[rt] <= writeback_value;
		end
	end

	assign retire.valid = writeback_enable && control.reg_write;
	assign retire.rt = rt;
	assign retire.value = writeback_value;

endmodule

`default_nettype wire

// ==== hw/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module fetch_unit (
	input logic clock,
	input logic reset,
	input logic pc_enable,
	input logic fetch_enable,
	input logic load_enable,
	input cpu_pkg::imem_addr_t load_address,
	input cpu_pkg::inst_t load_instruction,
	output cpu_pkg::inst_t instruction
);
	import cpu_pkg::*;

	pc_t pc;
	inst_t imem [0:`IMEM_DEPTH-1];
	inst_t imem_word;

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			pc <= '0;
		end else if (pc_enable) begin
			pc <= pc + 32'd4;
		end
	end

	// read uses the pc before it advances
	always_ff @(posedge clock) begin
		if (load_enable) begin
			imem[load_address] <= load_instruction;
		end
		if (pc_enable) begin
			imem_word <= imem[pc[`WORD_INDEX_FIELD]];
		end
	end

	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			instruction <= '0;
		end else if (fetch_enable) begin
			instruction <= imem_word;
		end
	end

endmodule

`default_nettype wire

// ==== hw/memory_writeback.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module memory_writeback (
	input logic clock,
	input logic reset,
	input logic memory_enable,
	input cpu_pkg::control_t control,
	input cpu_pkg::word_t alu_result,
	input cpu_pkg::word_t store_data,
	output cpu_pkg::word_t writeback_value,
	output cpu_pkg::store_t store
);
	import cpu_pkg::*;

	word_t dmem [0:`DMEM_DEPTH-1];
	word_t load_word;

	always_ff @(posedge clock) begin
		if (memory_enable && control.dm_write) begin
			dmem[alu_result[`WORD_INDEX_FIELD]] <= store_data;
		end
	end

	// loaded word is ready for the writeback state
	always_ff @(posedge clock or posedge reset) begin
		if (reset) begin
			load_word <= '0;
		end else if (memory_enable && control.dm_read) begin
			load_word <= dmem[alu_result[`WORD_INDEX_FIELD]];
		end
	end

	// movi already carries its immediate in alu_result
	assign writeback_value = (control.wb_sel == wb_mem) ? load_word : alu_result;

	assign store.valid = memory_enable && control.dm_write;
	assign store.address = alu_result;
	assign store.data = store_data;

endmodule

`default_nettype wire

// ==== testbench/cpu_assertions.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpu_assertions (
	input logic clock,
	input logic reset,
	input logic run,
	input logic pc_enable,
	input logic fetch_enable,
	input logic execute_enable,
	input logic memory_enable,
	input logic writeback_enable,
	input cpu_pkg::control_t control
);

	int failure_count = 0;

	// one stage at a time while the core runs
	one_stage_active: assert property (@(posedge clock) disable iff (reset)
		run |-> $onehot({pc_enable, fetch_enable, execute_enable, memory_enable, writeback_enable}))
		else begin
			$error("stage enables are not one-hot while run is high");
			failure_count++;
		end

	writeback_after_memory: assert property (@(posedge clock) disable iff (reset)
		memory_enable |=> writeback_enable)
		else begin
			$error("writeback did not follow the memory stage");
			failure_count++;
		end

	// a store never writes a register
	no_store_with_write: assert property (@(posedge clock) disable iff (reset)
		!(control.dm_write && control.reg_write))
		else begin
			$error("dm_write and reg_write are both set");
			failure_count++;
		end

endmodule

`default_nettype wire

// ==== testbench/cpu_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_tb;
	import cpu_pkg::*;

	typedef enum logic [4:0] {
		op_add, op_sub, op_and, op_or, op_xor,
		op_srli, op_slli, op_rotri,
		op_addi, op_ori, op_xori, op_movi,
		op_lwi, op_swi, op_lw, op_sw, op_undef
	} op_t;

	// rb doubles as the shift amount for shifts
	typedef struct packed {
		op_t op;
		reg_idx_t rt;
		reg_idx_t ra;
		reg_idx_t rb;
		logic [19:0] imm;
		logic [1:0] sv;
	} step_t;

	typedef enum logic [1:0] {
		pulse_retire,
		pulse_store
	} pulse_kind_t;

	typedef struct packed {
		pulse_kind_t kind;
		retire_t retire;
		store_t store;
	} pulse_t;

	logic clock;
	logic reset;
	logic run;
	logic load_enable;
	imem_addr_t load_address;
	inst_t load_instruction;
	retire_t retire;
	store_t store;

	step_t steps[$];
	pulse_t expected[$];
	word_t model_regs [0:31];
	word_t model_dmem [0:`DMEM_DEPTH-1];
	int cycle_count;
	int cycle_limit;

	cpu_top cpu_top_inst (
		.clock(clock),
		.reset(reset),
		.run(run),
		.load_enable(load_enable),
		.load_address(load_address),
		.load_instruction(load_instruction),
		.retire(retire),
		.store(store)
	);

	bind cpu_controller cpu_assertions cpu_assertions_inst (
		.clock(clock),
		.reset(reset),
		.run(run),
		.pc_enable(pc_enable),
		.fetch_enable(fetch_enable),
		.execute_enable(execute_enable),
		.memory_enable(memory_enable),
		.writeback_enable(writeback_enable),
		.control(control)
	);

	always #2 clock = ~clock;

	always @(posedge clock) begin
		if (run) begin
			cycle_count++;
			if (cycle_count > cycle_limit) begin
				$display("ERROR: program did not finish within %0d cycles", cycle_limit);
				$display(">>> FAIL");
				$fatal(1, "timeout");
			end
		end
	end

	always @(negedge clock) begin
		if (cpu_top_inst.cpu_controller_inst.cpu_assertions_inst.failure_count != 0) begin
			fail_run("a bound assertion on the controller sequence failed");
		end
	end

	task automatic fail_run(input string message);
		$display("%s", message);
		$display(">>> FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_retire(input retire_t actual, input retire_t wanted);
		if (actual !== wanted) begin
			fail_run($sformatf("CHECK FAILED at %0t: retire r%0d = %h, expected r%0d = %h",
				$time, actual.rt, actual.value, wanted.rt, wanted.value));
		end
	endtask

	task automatic check_store(input store_t actual, input store_t wanted);
		if (actual !== wanted) begin
			fail_run($sformatf("CHECK FAILED at %0t: store [%h] = %h, expected [%h] = %h",
				$time, actual.address, actual.data, wanted.address, wanted.data));
		end
	endtask

	task automatic add_step(input op_t op, input int rt, input int ra, input int rb,
		input logic [19:0] imm, input int sv);
		step_t step;
		step.op = op;
		step.rt = 5'(rt);
		step.ra = 5'(ra);
		step.rb = 5'(rb);
		step.imm = imm;
		step.sv = 2'(sv);
		steps.push_back(step);
	endtask

	function automatic inst_t encode(input step_t s);
		inst_t word;
		case (s.op)
			op_add: word = {1'b0, `TY_BASE, s.rt, s.ra, s.rb, 5'd0, `ADD};
			op_sub: word = {1'b0, `TY_BASE, s.rt, s.ra, s.rb, 5'd0, `SUB};
			op_and: word = {1'b0, `TY_BASE, s.rt, s.ra, s.rb, 5'd0, `AND};
			op_or: word = {1'b0, `TY_BASE, s.rt, s.ra, s.rb, 5'd0, `OR};
			op_xor: word = {1'b0, `TY_BASE, s.rt, s.ra, s.rb, 5'd0, `XOR};
			op_srli: word = {1'b0, `TY_BASE, s.rt, s.ra, s.rb, 5'd0, `SRLI};
			op_slli: word = {1'b0, `TY_BASE, s.rt, s.ra, s.rb, 5'd0, `SLLI};
			op_rotri: word = {1'b0, `TY_BASE, s.rt, s.ra, s.rb, 5'd0, `ROTRI};
			op_addi: word = {1'b0, `ADDI, s.rt, s.ra, s.imm[14:0]};
			op_ori: word = {1'b0, `ORI, s.rt, s.ra, s.imm[14:0]};
			op_xori: word = {1'b0, `XORI, s.rt, s.ra, s.imm[14:0]};
			op_movi: word = {1'b0, `MOVI, s.rt, s.imm};
			op_lwi: word = {1'b0, `LWI, s.rt, s.ra, s.imm[14:0]};
			op_swi: word = {1'b0, `SWI, s.rt, s.ra, s.imm[14:0]};
			op_lw: word = {1'b0, `TY_LS, s.rt, s.ra, s.rb, s.sv, `LW};
			op_sw: word = {1'b0, `TY_LS, s.rt, s.ra, s.rb, s.sv, `SW};
			default: word = {1'b0, 6'b111110, s.rt, s.ra, 15'd0};
		endcase
		return word;
	endfunction

	// undefined opcode with the word address in the low bits
	function automatic inst_t fill_word(input imem_addr_t address);
		return {1'b0, 6'b111111, 19'd0, address};
	endfunction

	task automatic model_step(input step_t s);
		word_t a;
		word_t b;
		word_t imm_s;
		word_t imm_z;
		word_t address;
		word_t value;
		pulse_t pulse;
		a = model_regs[s.ra];
		b = model_regs[s.rb];
		imm_s = {{17{s.imm[14]}}, s.imm[14:0]};
		imm_z = {17'd0, s.imm[14:0]};
		address = '0;
		value = '0;
		pulse = '0;
		case (s.op)
			op_add: value = a + b;
			op_sub: value = a - b;
			op_and: value = a & b;
			op_or: value = a | b;
			op_xor: value = a ^ b;
			op_srli: value = a >> s.rb;
			op_slli: value = a << s.rb;
			op_rotri: value = (s.rb == 5'd0) ? a : ((a >> s.rb) | (a << (6'd32 - {1'b0, s.rb})));
			op_addi: value = a + imm_s;
			op_ori: value = a | imm_z;
			op_xori: value = a ^ imm_z;
			op_movi: value = {{12{s.imm[19]}}, s.imm};
			op_lwi, op_swi: address = a + (imm_s << 2);
			op_lw, op_sw: address = a + (b << s.sv);
			default: value = '0;
		endcase
		if (s.op == op_swi || s.op == op_sw) begin
			model_dmem[address[7:2]] = model_regs[s.rt];
			pulse.kind = pulse_store;
			pulse.store = '{1'b1, address, model_regs[s.rt]};
			expected.push_back(pulse);
		end else if (s.op != op_undef) begin
			if (s.op == op_lwi || s.op == op_lw) begin
				value = model_dmem[address[7:2]];
			end
			model_regs[s.rt] = value;
			pulse.kind = pulse_retire;
			pulse.retire = '{1'b1, s.rt, value};
			expected.push_back(pulse);
		end
	endtask

	task automatic build_program();
		add_step(op_movi, 1, 0, 0, 20'hffffb, 0);
		add_step(op_movi, 2, 0, 0, 20'h004d2, 0);
		add_step(op_movi, 3, 0, 0, 20'($urandom()), 0);
		add_step(op_add, 4, 1, 2, 20'h0, 0);
		add_step(op_sub, 5, 2, 1, 20'h0, 0);
		add_step(op_and, 6, 3, 2, 20'h0, 0);
		add_step(op_or, 7, 3, 1, 20'h0, 0);
		add_step(op_xor, 8, 3, 2, 20'h0, 0);
		// shift amounts 0, 1 and 31
		add_step(op_srli, 9, 1, 0, 20'h0, 0);
		add_step(op_srli, 10, 1, 1, 20'h0, 0);
		add_step(op_srli, 11, 1, 31, 20'h0, 0);
		add_step(op_slli, 12, 3, 0, 20'h0, 0);
		add_step(op_slli, 13, 3, 1, 20'h0, 0);
		add_step(op_slli, 14, 3, 31, 20'h0, 0);
		add_step(op_rotri, 15, 3, 0, 20'h0, 0);
		add_step(op_rotri, 16, 2, 1, 20'h0, 0);
		add_step(op_rotri, 17, 2, 31, 20'h0, 0);
		add_step(op_addi, 18, 2, 0, 20'h07f9c, 0);
		add_step(op_addi, 19, 1, 0, 20'($urandom()) | 20'h04000, 0);
		add_step(op_ori, 20, 2, 0, 20'h04abc, 0);
		add_step(op_ori, 21, 3, 0, 20'($urandom()), 0);
		add_step(op_xori, 22, 2, 0, 20'h06001, 0);
		add_step(op_xori, 23, 1, 0, 20'($urandom()), 0);
		add_step(op_movi, 24, 0, 0, 20'($urandom()) | 20'h80000, 0);
		// stores followed by loads of the same word
		add_step(op_movi, 25, 0, 0, 20'h00010, 0);
		add_step(op_swi, 4, 25, 0, 20'h00003, 0);
		add_step(op_lwi, 26, 25, 0, 20'h00003, 0);
		add_step(op_movi, 27, 0, 0, 20'h00002, 0);
		add_step(op_sw, 5, 25, 27, 20'h0, 2);
		add_step(op_lw, 28, 25, 27, 20'h0, 2);
		add_step(op_movi, 29, 0, 0, 20'h00028, 0);
		add_step(op_sw, 7, 25, 29, 20'h0, 0);
		add_step(op_lw, 30, 25, 29, 20'h0, 0);
		add_step(op_swi, 8, 29, 0, 20'h07ffd, 0);
		add_step(op_lwi, 31, 29, 0, 20'h07ffd, 0);
		add_step(op_undef, 1, 1, 0, 20'h0, 0);
		add_step(op_addi, 1, 1, 0, 20'h00007, 0);
	endtask

	// no pulse may appear while run is low
	task automatic load_program();
		for (int a = 0; a < `IMEM_DEPTH; a++) begin
			@(posedge clock);
			#1;
			load_enable = 1'b1;
			load_address = imem_addr_t'(a);
			load_instruction = (a < steps.size()) ? encode(steps[a]) : fill_word(imem_addr_t'(a));
			@(negedge clock);
			if (retire.valid || store.valid) begin
				fail_run($sformatf("a retire or store pulse appeared at %0t while run was low", $time));
			end
		end
	endtask

	task automatic collect_pulses();
		pulse_t wanted;
		while (expected.size() > 0) begin
			@(negedge clock);
			if (retire.valid || store.valid) begin
				wanted = expected.pop_front();
				if (retire.valid && wanted.kind == pulse_retire) begin
					check_retire(retire, wanted.retire);
				end else if (store.valid && wanted.kind == pulse_store) begin
					check_store(store, wanted.store);
				end else begin
					fail_run($sformatf("at %0t the DUT pulsed retire=%b store=%b but a %s was due",
						$time, retire.valid, store.valid, wanted.kind.name()));
				end
			end
		end
	endtask

	initial begin
		clock = 1'b0;
		reset = 1'b1;
		run = 1'b0;
		load_enable = 1'b0;
		load_address = '0;
		load_instruction = '0;
		cycle_count = 0;
		void'($urandom(32'h72ae_1285));
		for (int i = 0; i < 32; i++) model_regs[i] = '0;
		build_program();
		foreach (steps[i]) model_step(steps[i]);
		cycle_limit = 5 * steps.size() + 20;
		repeat (2) @(posedge clock);
		#1;
		reset = 1'b0;
		load_program();
		@(posedge clock);
		#1;
		load_enable = 1'b0;
		run = 1'b1;
		collect_pulses();
		@(posedge clock);
		#1;
		run = 1'b0;
		if (cpu_top_inst.cpu_controller_inst.cpu_assertions_inst.failure_count != 0) begin
			fail_run("a bound assertion on the controller sequence failed");
		end else begin
			$display(">>> PASS");
			$finish;
		end
	end

endmodule

`default_nettype wire
